/* design/video_timing_pkg.sv */
package video_timing_pkg;

    // Counter widths cover 1650 columns and 750 lines
    typedef logic [10:0] h_count_t;
    typedef logic [9:0]  v_count_t;

    // Display start is fixed at zero on both axes
    typedef struct packed {
        h_count_t h_total;
        h_count_t h_active;
        h_count_t h_sync_start;
        h_count_t h_sync_end;
        logic     h_sync_pol;
        v_count_t v_total;
        v_count_t v_active;
        v_count_t v_sync_start;
        v_count_t v_sync_end;
        logic     v_sync_pol;
    } video_timing_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } sync_bus_t;

    // 1280x720 at 60 Hz, positive syncs
    localparam video_timing_t TIMING_720P = '{
        h_total: 11'd1650, h_active: 11'd1280, h_sync_start: 11'd1390,
        h_sync_end: 11'd1430, h_sync_pol: 1'b1,
        v_total: 10'd750, v_active: 10'd720, v_sync_start: 10'd725,
        v_sync_end: 10'd730, v_sync_pol: 1'b1
    };

endpackage

/* design/frame_pkg.sv */
package frame_pkg;

    // Side of the square window kept in the frame buffer
    localparam int FB_SIDE = 256;

    typedef logic [13:0] cam_coord_t;
    typedef logic [9:0]  raw_pixel_t;
    typedef logic [7:0]  fb_pixel_t;

    // Row in the high byte, column in the low byte
    typedef logic [15:0] fb_addr_t;

    typedef struct packed {
        logic      en;
        fb_addr_t  addr;
        fb_pixel_t data;
    } fb_write_t;

    // Display pixel, first byte in bits 23:16
    typedef logic [23:0] rgb_t;

endpackage

/* design/camera_window_writer.sv */
`timescale 1ns/1ns

module camera_window_writer
    import frame_pkg::*;
#(
    parameter int CAM_WIDTH  = 1280,
    parameter int CAM_HEIGHT = 720
) (
    input  logic       dvi_clk,
    input  logic       sys_reset,
    input  logic       cam_fv_i,
    input  logic       cam_lv_i,
    input  raw_pixel_t cam_pixel_i,
    output fb_write_t  fb_write_o
);

    logic       lv_prev;
    cam_coord_t col;
    cam_coord_t row;
    logic       col_in_win;
    logic       row_in_win;

    // ------------------------------
    // Camera coordinate tracking
    // ------------------------------
    always_ff @(posedge dvi_clk or posedge sys_reset) begin
        if (sys_reset) begin
            lv_prev <= 1'b0;
            col     <= '0;
            row     <= '0;
        end else begin
            lv_prev <= cam_lv_i;
            // Column counts pixels seen so far in this line
            col <= cam_lv_i ? col + 1'b1 : '0;
            if (!cam_fv_i) begin
                row <= '0;
            end else if (lv_prev && !cam_lv_i) begin
                row <= row + 1'b1;
            end
        end
    end

    // ------------------------------
    // Lower-right window
    // ------------------------------
    assign col_in_win = (col >= cam_coord_t'(CAM_WIDTH - FB_SIDE)) &&
                        (col < cam_coord_t'(CAM_WIDTH));
    assign row_in_win = (row >= cam_coord_t'(CAM_HEIGHT - FB_SIDE)) &&
                        (row < cam_coord_t'(CAM_HEIGHT));

    // Write lands on the same edge that samples the pixel
    assign fb_write_o.en   = cam_lv_i && col_in_win && row_in_win;
    assign fb_write_o.addr = {row[7:0], col[7:0]};
    assign fb_write_o.data = cam_pixel_i[9:2];

endmodule

/* design/frame_buffer_ram.sv */
`timescale 1ns/1ns

module frame_buffer_ram
    import frame_pkg::*;
(
    input  logic      dvi_clk,
    input  fb_write_t fb_write_i,
    input  fb_addr_t  rd_addr_i,
    output fb_pixel_t rd_data_o
);

    localparam int DEPTH = FB_SIDE * FB_SIDE;

    fb_pixel_t mem [DEPTH];

    // ------------------------------
    // Port 0, camera writes
    // ------------------------------
    always_ff @(posedge dvi_clk) begin
        if (fb_write_i.en) begin
            mem[fb_write_i.addr] <= fb_write_i.data;
        end
    end

    // ------------------------------
    // Port 1, display reads
    // ------------------------------

    // Read enable tied on, data valid one cycle after the address
    always_ff @(posedge dvi_clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* design/video_sync_gen.sv */
`timescale 1ns/1ns

module video_sync_gen
    import video_timing_pkg::*;
#(
    parameter video_timing_t TIMING = TIMING_720P
) (
    input  logic      dvi_clk,
    input  logic      sys_reset,
    output sync_bus_t sync_o,
    output h_count_t  x_o,
    output v_count_t  y_o
);

    h_count_t h_cnt;
    v_count_t v_cnt;
    logic     h_last;
    logic     v_last;
    logic     h_act;
    logic     v_act;
    logic     hs_act;
    logic     vs_act;

    assign h_last = (h_cnt == TIMING.h_total - 1'b1);
    assign v_last = (v_cnt == TIMING.v_total - 1'b1);

    // ------------------------------
    // Raster counters
    // ------------------------------
    always_ff @(posedge dvi_clk or posedge sys_reset) begin
        if (sys_reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_act  = (h_cnt < TIMING.h_active);
    assign v_act  = (v_cnt < TIMING.v_active);
    // Sync windows, end excluded
    assign hs_act = (h_cnt >= TIMING.h_sync_start) && (h_cnt < TIMING.h_sync_end);
    assign vs_act = (v_cnt >= TIMING.v_sync_start) && (v_cnt < TIMING.v_sync_end);

    // ------------------------------
    // Registered outputs
    // ------------------------------
    always_ff @(posedge dvi_clk or posedge sys_reset) begin
        if (sys_reset) begin
            sync_o.hsync <= !TIMING.h_sync_pol;
            sync_o.vsync <= !TIMING.v_sync_pol;
            sync_o.de    <= 1'b0;
            x_o          <= '0;
            y_o          <= '0;
        end else begin
            sync_o.hsync <= hs_act ? TIMING.h_sync_pol : !TIMING.h_sync_pol;
            sync_o.vsync <= vs_act ? TIMING.v_sync_pol : !TIMING.v_sync_pol;
            sync_o.de    <= h_act && v_act;
            // Coordinates only mean something inside the active area
            if (h_act && v_act) begin
                x_o <= h_cnt;
                y_o <= v_cnt;
            end else begin
                x_o <= '0;
                y_o <= '0;
            end
        end
    end

endmodule

/* design/display_pixel_source.sv */
`timescale 1ns/1ns

module display_pixel_source
    import video_timing_pkg::*;
    import frame_pkg::*;
(
    input  logic      dvi_clk,
    input  logic      sys_reset,
    input  sync_bus_t sync_i,
    input  h_count_t  x_i,
    input  v_count_t  y_i,
    input  logic      pattern_sel_i,
    output fb_addr_t  rd_addr_o,
    input  fb_pixel_t rd_data_i,
    output sync_bus_t sync_o,
    output rgb_t      rgb_o
);

    logic [7:0] xy_sum;
    rgb_t       pattern;
    sync_bus_t  sync_d;
    rgb_t       pattern_d;
    logic       sel_d;
    rgb_t       rgb_next;

    // Window row and column straight from the display coordinates
    assign rd_addr_o = {y_i[7:0], x_i[7:0]};

    // Coordinate test pattern
    assign xy_sum  = 8'(x_i + y_i);
    assign pattern = {xy_sum, y_i[7:0], x_i[7:0]};

    // ------------------------------
    // Stage 1, matches the RAM read
    // ------------------------------
    always_ff @(posedge dvi_clk or posedge sys_reset) begin
        if (sys_reset) begin
            sync_d    <= '0;
            pattern_d <= '0;
            sel_d     <= 1'b0;
        end else begin
            sync_d    <= sync_i;
            pattern_d <= pattern;
            sel_d     <= pattern_sel_i;
        end
    end

    // Grey video repeats the stored byte on all channels
    assign rgb_next = sel_d ? pattern_d : {3{rd_data_i}};

    // ------------------------------
    // Stage 2, output register
    // ------------------------------
    always_ff @(posedge dvi_clk or posedge sys_reset) begin
        if (sys_reset) begin
            sync_o <= '0;
            rgb_o  <= '0;
        end else begin
            sync_o <= sync_d;
            rgb_o  <= sync_d.de ? rgb_next : '0;
        end
    end

endmodule

/* design/video_top.sv */
`timescale 1ns/1ns

module video_top
    import video_timing_pkg::*;
    import frame_pkg::*;
#(
    parameter video_timing_t TIMING     = TIMING_720P,
    parameter int            CAM_WIDTH  = 1280,
    parameter int            CAM_HEIGHT = 720
) (
    input  logic       dvi_clk,
    input  logic       sys_reset,
    input  logic       cam_fv_i,
    input  logic       cam_lv_i,
    input  logic       pattern_sel_i,
    input  raw_pixel_t cam_pixel_i,
    output sync_bus_t  video_sync_o,
    output rgb_t       video_rgb_o
);

    fb_write_t fb_write;
    fb_addr_t  fb_rd_addr;
    fb_pixel_t fb_rd_data;
    sync_bus_t gen_sync;
    h_count_t  gen_x;
    v_count_t  gen_y;

    // ------------------------------
    // Camera side
    // ------------------------------
    camera_window_writer #(
        .CAM_WIDTH  (CAM_WIDTH),
        .CAM_HEIGHT (CAM_HEIGHT)
    ) u_writer (
        .dvi_clk     (dvi_clk),
        .sys_reset   (sys_reset),
        .cam_fv_i    (cam_fv_i),
        .cam_lv_i    (cam_lv_i),
        .cam_pixel_i (cam_pixel_i),
        .fb_write_o  (fb_write)
    );

    frame_buffer_ram u_ram (
        .dvi_clk    (dvi_clk),
        .fb_write_i (fb_write),
        .rd_addr_i  (fb_rd_addr),
        .rd_data_o  (fb_rd_data)
    );

    // ------------------------------
    // Display side
    // ------------------------------
    video_sync_gen #(
        .TIMING (TIMING)
    ) u_sync_gen (
        .dvi_clk   (dvi_clk),
        .sys_reset (sys_reset),
        .sync_o    (gen_sync),
        .x_o       (gen_x),
        .y_o       (gen_y)
    );

    display_pixel_source u_pixel_src (
        .dvi_clk       (dvi_clk),
        .sys_reset     (sys_reset),
        .sync_i        (gen_sync),
        .x_i           (gen_x),
        .y_i           (gen_y),
        .pattern_sel_i (pattern_sel_i),
        .rd_addr_o     (fb_rd_addr),
        .rd_data_i     (fb_rd_data),
        .sync_o        (video_sync_o),
        .rgb_o         (video_rgb_o)
    );

endmodule

/* sim/tb_video_top.sv */
`timescale 1ns/1ns

module tb_video_top
    import video_timing_pkg::*;
    import frame_pkg::*;
();

    localparam int CAM_W      = 264;
    localparam int CAM_H      = 260;
    localparam int LINE_GAP   = 8;
    localparam int H_TOTAL    = 300;
    localparam int H_ACTIVE   = 260;
    localparam int H_SYNC_LEN = 10;
    localparam int V_TOTAL    = 264;
    localparam int V_ACTIVE   = 258;
    localparam int V_SYNC_LEN = 2;
    localparam int VS_TIMEOUT = 2 * H_TOTAL * V_TOTAL;
    localparam int MODE_NONE    = 0;
    localparam int MODE_PATTERN = 1;
    localparam int MODE_BUFFER  = 2;

    localparam video_timing_t TB_TIMING = '{
        h_total: 11'(H_TOTAL), h_active: 11'(H_ACTIVE), h_sync_start: 11'd270,
        h_sync_end: 11'd280, h_sync_pol: 1'b1,
        v_total: 10'(V_TOTAL), v_active: 10'(V_ACTIVE), v_sync_start: 10'd259,
        v_sync_end: 10'd261, v_sync_pol: 1'b1
    };

    logic       dvi_clk = 1'b0;
    logic       sys_reset = 1'b1;
    logic       cam_fv;
    logic       cam_lv;
    logic       pattern_sel;
    raw_pixel_t cam_pixel;
    sync_bus_t  vid_sync;
    rgb_t       vid_rgb;

    int          errors = 0;
    int          check_mode;
    logic [31:0] lcg_state;
    fb_pixel_t   model [FB_SIDE * FB_SIDE];

    // Output trackers one step behind the pins
    logic post_reset = 1'b0;
    logic prev_hs;
    logic prev_vs;
    logic prev_de;
    logic hs_seen;
    logic vs_seen;
    int   hs_len;
    int   hs_gap;
    int   vs_len;
    int   vs_gap;
    int   de_col;
    int   de_row;
    logic hs_rise;
    logic hs_fall;
    logic vs_rise;
    logic vs_fall;
    logic de_fall;

    video_top #(
        .TIMING     (TB_TIMING),
        .CAM_WIDTH  (CAM_W),
        .CAM_HEIGHT (CAM_H)
    ) video_top_i (
        .dvi_clk       (dvi_clk),
        .sys_reset     (sys_reset),
        .cam_fv_i      (cam_fv),
        .cam_lv_i      (cam_lv),
        .pattern_sel_i (pattern_sel),
        .cam_pixel_i   (cam_pixel),
        .video_sync_o  (vid_sync),
        .video_rgb_o   (vid_rgb)
    );

    initial begin
        forever #50 dvi_clk = ~dvi_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Coordinate pattern as sum then row then column
    function automatic rgb_t pattern_rgb(input int col, input int row);
        return {8'(col + row), 8'(row), 8'(col)};
    endfunction

    function automatic rgb_t grey_rgb(input int col, input int row);
        fb_addr_t a;
        a = {8'(row), 8'(col)};
        return {3{model[a]}};
    endfunction

    assign hs_rise = vid_sync.hsync && !prev_hs;
    assign hs_fall = !vid_sync.hsync && prev_hs;
    assign vs_rise = vid_sync.vsync && !prev_vs;
    assign vs_fall = !vid_sync.vsync && prev_vs;
    assign de_fall = !vid_sync.de && prev_de;

    always @(posedge dvi_clk or posedge sys_reset) begin
        if (sys_reset) begin
            post_reset <= 1'b1;
            prev_hs <= 1'b0;
            prev_vs <= 1'b0;
            prev_de <= 1'b0;
            hs_seen <= 1'b0;
            vs_seen <= 1'b0;
            hs_len <= 0;
            hs_gap <= 0;
            vs_len <= 0;
            vs_gap <= 0;
            de_col <= 0;
            de_row <= 0;
        end else begin
            post_reset <= 1'b0;
            prev_hs <= vid_sync.hsync;
            prev_vs <= vid_sync.vsync;
            prev_de <= vid_sync.de;
            hs_len <= vid_sync.hsync ? hs_len + 1 : 0;
            vs_len <= vid_sync.vsync ? vs_len + 1 : 0;
            hs_gap <= hs_rise ? 1 : hs_gap + 1;
            vs_gap <= vs_rise ? 1 : vs_gap + 1;
            if (hs_rise) begin
                hs_seen <= 1'b1;
            end
            if (vs_rise) begin
                vs_seen <= 1'b1;
            end
            de_col <= vid_sync.de ? de_col + 1 : 0;
            // Row of de lines restarts inside the vsync pulse
            if (vid_sync.vsync) begin
                de_row <= 0;
            end else if (de_fall) begin
                de_row <= de_row + 1;
            end
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    assert property (@(posedge dvi_clk) post_reset |->
        (!vid_sync.de && !vid_sync.hsync && !vid_sync.vsync && vid_rgb == '0))
        else begin
            errors++;
            $display("mismatch reset_idle: expected %h, actual %h", 27'h0,
                     {$sampled(vid_sync), $sampled(vid_rgb)});
        end

    assert property (@(posedge dvi_clk) disable iff (sys_reset) hs_fall |-> hs_len == H_SYNC_LEN)
        else begin
            errors++;
            $display("mismatch hsync_width: expected %0d, actual %0d", H_SYNC_LEN,
                     $sampled(hs_len));
        end

    // A missing pulse lets the gap run past one line
    assert property (@(posedge dvi_clk) disable iff (sys_reset)
        hs_rise ? (!hs_seen || hs_gap == H_TOTAL) : hs_gap != H_TOTAL + 1)
        else begin
            errors++;
            $display("mismatch hsync_period: expected %0d, actual %0d", H_TOTAL,
                     $sampled(hs_gap));
        end

    assert property (@(posedge dvi_clk) disable iff (sys_reset)
        vs_fall |-> vs_len == V_SYNC_LEN * H_TOTAL)
        else begin
            errors++;
            $display("mismatch vsync_width: expected %0d, actual %0d", V_SYNC_LEN * H_TOTAL,
                     $sampled(vs_len));
        end

    assert property (@(posedge dvi_clk) disable iff (sys_reset)
        (vs_rise && vs_seen) |-> vs_gap == V_TOTAL * H_TOTAL)
        else begin
            errors++;
            $display("mismatch vsync_period: expected %0d, actual %0d", V_TOTAL * H_TOTAL,
                     $sampled(vs_gap));
        end

    assert property (@(posedge dvi_clk) disable iff (sys_reset) de_fall |-> de_col == H_ACTIVE)
        else begin
            errors++;
            $display("mismatch de_per_line: expected %0d, actual %0d", H_ACTIVE,
                     $sampled(de_col));
        end

    assert property (@(posedge dvi_clk) disable iff (sys_reset) vs_rise |-> de_row == V_ACTIVE)
        else begin
            errors++;
            $display("mismatch de_lines: expected %0d, actual %0d", V_ACTIVE, $sampled(de_row));
        end

    assert property (@(posedge dvi_clk) disable iff (sys_reset) !vid_sync.de |-> vid_rgb == '0)
        else begin
            errors++;
            $display("mismatch blanking: expected %h, actual %h", 24'h0, $sampled(vid_rgb));
        end

    assert property (@(posedge dvi_clk) disable iff (sys_reset)
        (vid_sync.de && check_mode == MODE_PATTERN) |-> vid_rgb == pattern_rgb(de_col, de_row))
        else begin
            errors++;
            $display("mismatch pattern: expected %h, actual %h",
                     pattern_rgb($sampled(de_col), $sampled(de_row)), $sampled(vid_rgb));
        end

    assert property (@(posedge dvi_clk) disable iff (sys_reset)
        (vid_sync.de && check_mode == MODE_BUFFER) |-> vid_rgb == grey_rgb(de_col, de_row))
        else begin
            errors++;
            $display("mismatch buffer: expected %h, actual %h",
                     grey_rgb($sampled(de_col), $sampled(de_row)), $sampled(vid_rgb));
        end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic drive_camera_frame();
        int r;
        int c;
        cam_fv = 1'b1;
        for (r = 0; r < CAM_H; r++) begin
            cam_lv = 1'b1;
            for (c = 0; c < CAM_W; c++) begin
                lcg_state = lcg_next(lcg_state);
                cam_pixel = lcg_state[31:22];
                // Lower-right window only
                if (c >= CAM_W - FB_SIDE && r >= CAM_H - FB_SIDE) begin
                    model[{r[7:0], c[7:0]}] = cam_pixel[9:2];
                end
                @(negedge dvi_clk);
            end
            cam_lv = 1'b0;
            repeat (LINE_GAP) @(negedge dvi_clk);
        end
        cam_fv = 1'b0;
    endtask

    task automatic wait_vsync_rise(output bit ok);
        int   n;
        logic last;
        ok = 1'b0;
        n = 0;
        last = vid_sync.vsync;
        while (!ok && n < VS_TIMEOUT) begin
            @(negedge dvi_clk);
            ok = vid_sync.vsync && !last;
            last = vid_sync.vsync;
            n++;
        end
        if (!ok) begin
            errors++;
            $display("timeout: no vsync pulse seen within %0d cycles", VS_TIMEOUT);
        end
    endtask

    initial begin
        bit ok;
        cam_fv = 1'b0;
        cam_lv = 1'b0;
        cam_pixel = '0;
        pattern_sel = 1'b0;
        check_mode = MODE_NONE;
        lcg_state = 32'h253e4d0b;
        repeat (2) @(negedge dvi_clk);
        sys_reset = 1'b0;
        repeat (4) @(negedge dvi_clk);
        drive_camera_frame();
        // Mode changes only right after a vsync edge deep in blanking
        wait_vsync_rise(ok);
        if (ok) begin
            pattern_sel = 1'b1;
            check_mode = MODE_PATTERN;
            wait_vsync_rise(ok);
        end
        if (ok) begin
            pattern_sel = 1'b0;
            check_mode = MODE_BUFFER;
            wait_vsync_rise(ok);
        end
        check_mode = MODE_NONE;
        repeat (2) @(negedge dvi_clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* list.f */
design/video_timing_pkg.sv
design/frame_pkg.sv
design/camera_window_writer.sv
design/frame_buffer_ram.sv
design/video_sync_gen.sv
design/display_pixel_source.sv
design/video_top.sv
sim/tb_video_top.sv
